// File: design/fm_acc_params.svh
// Widths and frame length for the FM output accumulator
// Running sum must be wider than both the ADPCM inputs and the output
// Set FM_NOMIX to 1'b1 to mute the ADPCM slots
`ifndef FM_ACC_PARAMS_SVH
`define FM_ACC_PARAMS_SVH

// Signed operator result
`define FM_OP_W 14

// ADPCM samples and stereo output
`define FM_SND_W 16

// Internal running sum, saturated on overflow
`define FM_ACC_W 18

// 6 channels x 4 operators
`define FM_SLOTS 24

// ADPCM slots mixed in when low
`define FM_NOMIX 1'b0

`endif

// File: design/fm_acc_pkg.sv
// Types shared by the FM output accumulator blocks
// Operator slot codes follow the chip's S1, S3, S2, S4 order
package fm_acc_pkg;

    // Operator that owns the current time slot
    typedef enum logic [1:0] {
        S1 = 2'd0,
        S3 = 2'd1,  // Chip order, not numeric order
        S2 = 2'd2,
        S4 = 2'd3
    } op_slot_t;

    // Connection algorithm of a channel
    // Only the carrier pattern matters here
    typedef enum logic [2:0] {
        ALG0 = 3'd0,  // Serial chain, S4 out
        ALG1 = 3'd1,
        ALG2 = 3'd2,
        ALG3 = 3'd3,
        ALG4 = 3'd4,  // Two pairs, S2 and S4 out
        ALG5 = 3'd5,
        ALG6 = 3'd6,
        ALG7 = 3'd7   // All four operators out
    } alg_t;

endpackage

// File: design/fm_slot_seq.sv
// Time-slot sequencer, operator-major, channel codes 0,1,2,4,5,6
// Codes 3 and 7 never appear on cur_ch
// All outputs registered, they describe the slot sampled at the next clk_en
`timescale 1ns/1ps
`include "fm_acc_params.svh"

module fm_slot_seq (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clk_en,
    output logic [2:0]           cur_ch,
    output fm_acc_pkg::op_slot_t cur_op,
    output logic                 s1_enters,
    output logic                 s2_enters,
    output logic                 s3_enters,
    output logic                 s4_enters,
    output logic                 zero,       // First slot of the frame
    output logic                 frame_end   // Last slot of the frame
);
    import fm_acc_pkg::*;

    localparam int               IDX_W = $clog2(`FM_SLOTS);
    localparam logic [IDX_W-1:0] LAST  = IDX_W'(`FM_SLOTS - 1);

    logic [IDX_W-1:0] idx;      // Linear slot index within the frame
    logic [IDX_W-1:0] idx_nxt;
    logic [2:0]       ch_nxt;
    logic             ch_wrap;  // Channel row done, step operator
    op_slot_t         op_nxt;

    // Channel step with the unused codes skipped
    always_comb begin
        ch_wrap = 1'b0;
        case (cur_ch)
            3'd0: ch_nxt = 3'd1;
            3'd1: ch_nxt = 3'd2;
            3'd2: ch_nxt = 3'd4;  // Jump over code 3
            3'd4: ch_nxt = 3'd5;
            3'd5: ch_nxt = 3'd6;
            default: begin
                ch_nxt  = 3'd0;   // Code 6 closes the row
                ch_wrap = 1'b1;
            end
        endcase
    end

    // S4 wraps back to S1 through the 2-bit add
    assign op_nxt  = ch_wrap ? op_slot_t'(cur_op + 2'd1) : cur_op;
    assign idx_nxt = (idx == LAST) ? '0 : idx + IDX_W'(1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx       <= '0;
            cur_ch    <= 3'd0;
            cur_op    <= S1;
            s1_enters <= 1'b1;  // Slot 0 belongs to S1
            s2_enters <= 1'b0;
            s3_enters <= 1'b0;
            s4_enters <= 1'b0;
            zero      <= 1'b1;
            frame_end <= 1'b0;
        end else if (clk_en) begin
            idx       <= idx_nxt;
            cur_ch    <= ch_nxt;
            cur_op    <= op_nxt;
            // One-hot decode of the incoming operator
            s1_enters <= (op_nxt == S1);
            s2_enters <= (op_nxt == S2);
            s3_enters <= (op_nxt == S3);
            s4_enters <= (op_nxt == S4);
            zero      <= (idx_nxt == '0);
            frame_end <= (idx_nxt == LAST);
        end
    end

endmodule

// File: design/fm_single_acc.sv
// One channel of the stereo accumulator
// Running sum is FM_ACC_W wide and clamps instead of wrapping
// WIN and WOUT must both be below FM_ACC_W
`timescale 1ns/1ps
`include "fm_acc_params.svh"

module fm_single_acc #(
    parameter int WIN  = 16,
    parameter int WOUT = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clk_en,
    input  logic signed [WIN-1:0]  acc_in,
    input  logic                   add_en,
    input  logic                   zero,   // Frame boundary slot
    output logic signed [WOUT-1:0] snd
);
    localparam int ACC_W = `FM_ACC_W;

    logic signed [ACC_W-1:0] sum;      // Running total of the frame
    logic signed [ACC_W-1:0] in_ext;
    logic signed [ACC_W-1:0] base;
    logic signed [ACC_W:0]   total;    // One guard bit for overflow
    logic signed [ACC_W-1:0] sum_nxt;
    logic [ACC_W-WOUT:0]     sum_hi;   // Bits that must agree to fit WOUT
    logic signed [WOUT-1:0]  sum_sat;

    assign in_ext = {{(ACC_W-WIN){acc_in[WIN-1]}}, acc_in};
    assign base   = zero ? '0 : sum;  // New frame starts from nothing

    assign total = add_en ? {base[ACC_W-1], base} + {in_ext[ACC_W-1], in_ext}
                          : {base[ACC_W-1], base};

    // Clamp the running sum at the ACC_W rails
    always_comb begin
        if (total[ACC_W] != total[ACC_W-1])
            sum_nxt = {total[ACC_W], {(ACC_W-1){~total[ACC_W]}}};
        else
            sum_nxt = total[ACC_W-1:0];
    end

    // Output saturation, applied to the old total on latch
    assign sum_hi  = sum[ACC_W-1:WOUT-1];
    assign sum_sat = (&sum_hi || ~|sum_hi) ? sum[WOUT-1:0]
                                           : {sum[ACC_W-1], {(WOUT-1){~sum[ACC_W-1]}}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum <= '0;
            snd <= '0;
        end else if (clk_en) begin
            sum <= sum_nxt;
            if (zero)
                snd <= sum_sat;  // Previous frame's total
        end
    end

endmodule

// File: design/fm_mix_acc.sv
// Per-slot input selection for the stereo accumulators
// Channel codes 2 and 6 lose their S1 slot to ADPCM-A and ADPCM-B
// ADPCM-B is halved to match the operator level
`timescale 1ns/1ps
`include "fm_acc_params.svh"

module fm_mix_acc (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        clk_en,
    input  logic signed [`FM_OP_W-1:0]  op_result,
    input  logic [1:0]                  rl,        // Bit 1 left, bit 0 right
    input  fm_acc_pkg::alg_t            alg,
    input  logic [2:0]                  cur_ch,
    input  fm_acc_pkg::op_slot_t        cur_op,
    input  logic                        s1_enters,
    input  logic                        s2_enters,
    input  logic                        s3_enters,
    input  logic                        s4_enters,
    input  logic                        zero,
    input  logic signed [`FM_SND_W-1:0] adpcm_a_l,
    input  logic signed [`FM_SND_W-1:0] adpcm_a_r,
    input  logic signed [`FM_SND_W-1:0] adpcm_b_l,
    input  logic signed [`FM_SND_W-1:0] adpcm_b_r,
    output logic signed [`FM_SND_W-1:0] left,
    output logic signed [`FM_SND_W-1:0] right
);
    import fm_acc_pkg::*;

    logic                        carrier;  // Slot output reaches the DAC
    logic                        mix_on;
    logic                        adpcm_a_slot;
    logic                        adpcm_b_slot;
    logic signed [`FM_SND_W-1:0] op_ext;
    logic signed [`FM_SND_W-1:0] in_l;
    logic signed [`FM_SND_W-1:0] in_r;
    logic                        en_l;
    logic                        en_r;

    // Carrier set per algorithm
    always_comb begin
        case (alg)
            ALG4:       carrier = s2_enters | s4_enters;
            ALG5, ALG6: carrier = s2_enters | s3_enters | s4_enters;
            ALG7:       carrier = 1'b1;
            default:    carrier = s4_enters;  // ALG0 to ALG3, S4 only
        endcase
    end

    assign op_ext       = {{(`FM_SND_W-`FM_OP_W){op_result[`FM_OP_W-1]}}, op_result};
    assign mix_on       = ~`FM_NOMIX;
    assign adpcm_a_slot = (cur_op == S1) && (cur_ch == 3'd2);
    assign adpcm_b_slot = (cur_op == S1) && (cur_ch == 3'd6);

    always_comb begin
        in_l = op_ext;
        in_r = op_ext;
        en_l = carrier & rl[1];
        en_r = carrier & rl[0];
        if (adpcm_a_slot) begin
            in_l = adpcm_a_l;        // FM value of this slot discarded
            in_r = adpcm_a_r;
            en_l = mix_on;           // Pan bits do not apply
            en_r = mix_on;
        end else if (adpcm_b_slot) begin
            in_l = adpcm_b_l >>> 1;  // Arithmetic halving
            in_r = adpcm_b_r >>> 1;
            en_l = mix_on;
            en_r = mix_on;
        end
    end

    fm_single_acc #(
        .WIN  (`FM_SND_W),
        .WOUT (`FM_SND_W)
    ) u_left (
        .clk    (clk),
        .rst_n  (rst_n),
        .clk_en (clk_en),
        .acc_in (in_l),
        .add_en (en_l),
        .zero   (zero),
        .snd    (left)
    );

    fm_single_acc #(
        .WIN  (`FM_SND_W),
        .WOUT (`FM_SND_W)
    ) u_right (
        .clk    (clk),
        .rst_n  (rst_n),
        .clk_en (clk_en),
        .acc_in (in_r),
        .add_en (en_r),
        .zero   (zero),
        .snd    (right)
    );

endmodule

// File: design/fm_acc_top.sv
// Sound-output accumulator top, fixed-rate, no back-pressure
// Source must present op_result, alg and rl for the slot on cur_ch/cur_op
// ADPCM inputs must stay steady for the whole frame
// sample_valid lasts one clk and must be taken when high
`timescale 1ns/1ps
`include "fm_acc_params.svh"

module fm_acc_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        clk_en,
    input  logic signed [`FM_OP_W-1:0]  op_result,
    input  fm_acc_pkg::alg_t            alg,
    input  logic [1:0]                  rl,
    input  logic signed [`FM_SND_W-1:0] adpcm_a_l,
    input  logic signed [`FM_SND_W-1:0] adpcm_a_r,
    input  logic signed [`FM_SND_W-1:0] adpcm_b_l,
    input  logic signed [`FM_SND_W-1:0] adpcm_b_r,
    output logic [2:0]                  cur_ch,
    output fm_acc_pkg::op_slot_t        cur_op,
    output logic signed [`FM_SND_W-1:0] left,
    output logic signed [`FM_SND_W-1:0] right,
    output logic                        sample_valid
);
    logic s1_enters;
    logic s2_enters;
    logic s3_enters;
    logic s4_enters;
    logic zero;
    logic frame_end;
    logic end_q;  // A full frame was sampled, next latch is good

    fm_slot_seq u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .cur_ch    (cur_ch),
        .cur_op    (cur_op),
        .s1_enters (s1_enters),
        .s2_enters (s2_enters),
        .s3_enters (s3_enters),
        .s4_enters (s4_enters),
        .zero      (zero),
        .frame_end (frame_end)
    );

    fm_mix_acc u_mix (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .op_result (op_result),
        .rl        (rl),
        .alg       (alg),
        .cur_ch    (cur_ch),
        .cur_op    (cur_op),
        .s1_enters (s1_enters),
        .s2_enters (s2_enters),
        .s3_enters (s3_enters),
        .s4_enters (s4_enters),
        .zero      (zero),
        .adpcm_a_l (adpcm_a_l),
        .adpcm_a_r (adpcm_a_r),
        .adpcm_b_l (adpcm_b_l),
        .adpcm_b_r (adpcm_b_r),
        .left      (left),
        .right     (right)
    );

    // end_q starts cleared, so the start-up latch at slot 0 is masked
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            end_q        <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= clk_en & end_q;  // Same edge that latches snd
            if (clk_en)
                end_q <= frame_end;
        end
    end

endmodule

// File: testbench/tb_fm_acc_top.sv
// Self-checking testbench for the FM output accumulator
// Run from the project root, frames come from testbench/fm_acc_cases.txt
// clk_en is tied high, so one slot per clk and one frame per 24 clk
`timescale 1ns/1ps
`include "fm_acc_params.svh"

module tb_fm_acc_top;
    import fm_acc_pkg::*;

    localparam int MAX_CASES = 64;
    localparam int CLK_HALF  = 20;  // 40 ns period

    logic                        clk;
    logic                        rst_n;
    logic                        clk_en;
    logic signed [`FM_OP_W-1:0]  op_result;
    alg_t                        alg;
    logic [1:0]                  rl;
    logic signed [`FM_SND_W-1:0] adpcm_a_l;
    logic signed [`FM_SND_W-1:0] adpcm_a_r;
    logic signed [`FM_SND_W-1:0] adpcm_b_l;
    logic signed [`FM_SND_W-1:0] adpcm_b_r;
    logic [2:0]                  cur_ch;
    op_slot_t                    cur_op;
    logic signed [`FM_SND_W-1:0] left;
    logic signed [`FM_SND_W-1:0] right;
    logic                        sample_valid;

    // Frame table from the cases file
    logic [2:0]           c_alg   [MAX_CASES];
    logic [1:0]           c_rl    [MAX_CASES];
    logic [`FM_OP_W-1:0]  c_v     [MAX_CASES];
    logic [`FM_SND_W-1:0] c_a_l   [MAX_CASES];
    logic [`FM_SND_W-1:0] c_a_r   [MAX_CASES];
    logic [`FM_SND_W-1:0] c_b_l   [MAX_CASES];
    logic [`FM_SND_W-1:0] c_b_r   [MAX_CASES];
    logic [`FM_SND_W-1:0] c_exp_l [MAX_CASES];
    logic [`FM_SND_W-1:0] c_exp_r [MAX_CASES];

    int n_cases;
    int errors;
    int valid_seen;  // sample_valid pulses so far
    int cycles;      // Rising edges since time 0
    int limit;
    bit loaded;

    fm_acc_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .clk_en       (clk_en),
        .op_result    (op_result),
        .alg          (alg),
        .rl           (rl),
        .adpcm_a_l    (adpcm_a_l),
        .adpcm_a_r    (adpcm_a_r),
        .adpcm_b_l    (adpcm_b_l),
        .adpcm_b_r    (adpcm_b_r),
        .cur_ch       (cur_ch),
        .cur_op       (cur_op),
        .left         (left),
        .right        (right),
        .sample_valid (sample_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    // Hex columns, '#' lines skipped
    task automatic load_cases();
        int          fd;
        int          got;
        string       line;
        logic [31:0] f_alg, f_rl, f_v, f_al, f_ar, f_bl, f_br, f_el, f_er;
        fd = $fopen("testbench/fm_acc_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the cases file");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                got = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_alg, f_rl, f_v,
                              f_al, f_ar, f_bl, f_br, f_el, f_er);
                if (got == 9 && n_cases < MAX_CASES) begin
                    c_alg[n_cases]   = f_alg[2:0];
                    c_rl[n_cases]    = f_rl[1:0];
                    c_v[n_cases]     = f_v[`FM_OP_W-1:0];  // Two's complement in file
                    c_a_l[n_cases]   = f_al[`FM_SND_W-1:0];
                    c_a_r[n_cases]   = f_ar[`FM_SND_W-1:0];
                    c_b_l[n_cases]   = f_bl[`FM_SND_W-1:0];
                    c_b_r[n_cases]   = f_br[`FM_SND_W-1:0];
                    c_exp_l[n_cases] = f_el[`FM_SND_W-1:0];
                    c_exp_r[n_cases] = f_er[`FM_SND_W-1:0];
                    n_cases++;
                end else if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    $display("Unreadable line in the cases file: %s", line);
                    errors++;
                end
            end
            $fclose(fd);
        end
        if (n_cases == 0) begin
            $display("No test frames found in the cases file");
            errors++;
        end
    endtask

    // Starts and ends on a falling edge; k < 0 plays a silent flush frame
    task automatic play_frame(input int k);
        assert (cur_ch == 3'd0 && cur_op == S1) else begin
            $display("Slot sequencer is not at slot 0 when frame %0d starts", k);
            errors++;
        end
        alg       = (k >= 0) ? alg_t'(c_alg[k]) : ALG0;
        rl        = (k >= 0) ? c_rl[k] : 2'b00;
        adpcm_a_l = (k >= 0) ? c_a_l[k] : '0;  // Steady for the whole frame
        adpcm_a_r = (k >= 0) ? c_a_r[k] : '0;
        adpcm_b_l = (k >= 0) ? c_b_l[k] : '0;
        adpcm_b_r = (k >= 0) ? c_b_r[k] : '0;
        for (int s = 0; s < `FM_SLOTS; s++) begin
            op_result = (k >= 0) ? c_v[k] : '0;  // Same value in every slot
            @(negedge clk);
        end
    endtask

    task automatic check_sample(input int k);
        assert (left === c_exp_l[k]) else begin
            $display("ERROR left: expected %h, actual %h, frame %0d", c_exp_l[k], left, k);
            errors++;
        end
        assert (right === c_exp_r[k]) else begin
            $display("ERROR right: expected %h, actual %h, frame %0d", c_exp_r[k], right, k);
            errors++;
        end
    endtask

    // Output monitor, sampled mid-cycle
    initial begin
        int last_valid;
        last_valid = -1;
        forever begin
            @(negedge clk);
            if (sample_valid) begin
                assert (valid_seen < n_cases) else begin
                    $display("sample_valid pulsed with no frame left to check");
                    errors++;
                end
                if (valid_seen < n_cases)
                    check_sample(valid_seen);
                if (last_valid >= 0) begin
                    assert (cycles - last_valid == `FM_SLOTS) else begin
                        $display("sample_valid came %0d cycles after the previous one",
                                 cycles - last_valid);
                        errors++;
                    end
                end
                last_valid = cycles;
                valid_seen++;
            end
        end
    end

    // Run limit from the number of frames
    initial begin
        cycles = 0;
        wait (loaded);
        limit = (n_cases + 3) * `FM_SLOTS + 50;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d of %0d samples seen",
                 cycles, valid_seen, n_cases);
        $display("Errors: %0d", errors);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        clk_en     = 1'b1;  // Full rate
        op_result  = '0;
        alg        = ALG0;
        rl         = 2'b00;
        adpcm_a_l  = '0;
        adpcm_a_r  = '0;
        adpcm_b_l  = '0;
        adpcm_b_r  = '0;
        errors     = 0;
        valid_seen = 0;
        n_cases    = 0;
        load_cases();
        loaded = 1'b1;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;  // Next rising edge samples slot 0
        for (int k = 0; k < n_cases; k++)
            play_frame(k);
        play_frame(-1);  // Latches the last case
        while (valid_seen < n_cases)
            @(negedge clk);
        $display("Errors: %0d, samples checked: %0d of %0d", errors, valid_seen, n_cases);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: testbench/fm_acc_cases.txt
# alg rl v a_l a_r b_l b_r exp_left exp_right, all hex, two's complement
# v is 14 bit, every other column 16 bit; one line is one frame
0 3 0100 0000 0000 0000 0000 0600 0600
4 3 0100 0000 0000 0000 0000 0c00 0c00
5 3 0100 0000 0000 0000 0000 1200 1200
7 3 0100 0000 0000 0000 0000 1600 1600
6 3 0010 0000 0000 0000 0000 0120 0120
1 3 3ff0 0000 0000 0000 0000 ffa0 ffa0
2 2 0200 0000 0000 0000 0000 0c00 0000
4 1 0080 0000 0000 0000 0000 0000 0600
7 0 0100 0000 0000 0000 0000 0000 0000
0 3 0000 1000 0234 0800 0100 1400 02b4
7 0 0000 fc00 0010 f001 0003 f400 0011
7 3 1fff 0000 0000 0000 0000 7fff 7fff
7 3 2000 0000 0000 0000 0000 8000 8000
5 2 1fff 0000 0000 0000 0000 7fff 0000
3 3 0040 0100 ff00 0020 fffe 0290 007f
4 1 0010 0040 0040 0040 0040 0060 0120
0 3 1555 0000 0000 0000 0000 7ffe 7ffe
0 3 1555 0001 0000 0002 0000 7fff 7ffe
0 3 0000 0000 0000 0000 0000 0000 0000

// File: fm_acc_top.f
+incdir+design
design/fm_acc_pkg.sv
design/fm_slot_seq.sv
design/fm_single_acc.sv
design/fm_mix_acc.sv
design/fm_acc_top.sv
testbench/tb_fm_acc_top.sv
